/* build.f */
hw/fcore_isa_pkg.sv
hw/fcore_dp_pkg.sv
hw/instr_decoder.sv
hw/register_file.sv
hw/popcount_pipe.sv
hw/bitfield_pipe.sv
hw/bitmanip_unit.sv
hw/bitmanip_core.sv
tb/bitmanip_core_tb.sv

/* hw/bitfield_pipe.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bit field pipeline
// Single bit extract and insert, plus the load-immediate pass-through
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module bitfield_pipe (
    input  logic                    clock,
    input  logic                    rst_n,
    input  fcore_dp_pkg::exec_req_t req,
    output fcore_dp_pkg::exec_res_t result
);

    import fcore_isa_pkg::*;
    import fcore_dp_pkg::*;

    localparam int IDX_W = $clog2(DATA_WIDTH);

    logic                  s1_valid;
    op_e                   s1_op;
    reg_addr_t             s1_dest;
    logic [DATA_WIDTH-1:0] s1_value;
    logic [IDX_W-1:0]      s1_index;
    logic                  s1_bit;

    logic                  s2_valid;
    reg_addr_t             s2_dest;
    logic [DATA_WIDTH-1:0] s2_data;
    logic [DATA_WIDTH-1:0] s2_next;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= req.valid;
            s2_valid <= s1_valid;
        end
    end

    // Only the low bits of operand_b select the bit position
    always_ff @(posedge clock) begin
        s1_op    <= req.op;
        s1_dest  <= req.dest;
        s1_value <= req.operand_a;
        s1_index <= req.operand_b[IDX_W-1:0];
        s1_bit   <= req.operand_c[0];
        s2_dest  <= s1_dest;
        s2_data  <= s2_next;
    end

    always_comb begin
        s2_next = '0;
        case (s1_op)
            OP_BEXT: s2_next[0] = s1_value[s1_index];
            OP_BINS: begin
                s2_next = s1_value;
                s2_next[s1_index] = s1_bit;
            end
            OP_LDI:  s2_next = s1_value;
            default: s2_next = '0;
        endcase
    end

    always_comb begin
        result = '0;
        if (s2_valid) begin
            result.valid = 1'b1;
            result.dest  = s2_dest;
            result.data  = s2_data;
        end
    end

    // Steering in the unit must keep other opcodes out of this pipe
    assert property (@(posedge clock) disable iff (!rst_n)
        s1_valid |-> (s1_op inside {OP_BEXT, OP_BINS, OP_LDI}))
    else $error("bit field pipe got unsupported opcode %0h", s1_op);

endmodule

/* hw/bitmanip_core.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level of the bit-manipulation slice
// Connects decoder, register file and execution unit and routes the
// merged result to the writeback port and to the output
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module bitmanip_core #(
    parameter int REG_COUNT = 16
) (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    instr_valid,
    input  fcore_isa_pkg::instr_u   instr,
    output fcore_dp_pkg::exec_res_t result
);

    import fcore_isa_pkg::*;
    import fcore_dp_pkg::*;

    reg_addr_t             rd_addr_a;
    reg_addr_t             rd_addr_b;
    reg_addr_t             rd_addr_c;
    logic [DATA_WIDTH-1:0] rd_data_a;
    logic [DATA_WIDTH-1:0] rd_data_b;
    logic [DATA_WIDTH-1:0] rd_data_c;
    exec_req_t             exec_req;

    instr_decoder instr_decoder_inst (
        .instr_valid (instr_valid),
        .instr       (instr),
        .rd_addr_a   (rd_addr_a),
        .rd_addr_b   (rd_addr_b),
        .rd_addr_c   (rd_addr_c),
        .rd_data_a   (rd_data_a),
        .rd_data_b   (rd_data_b),
        .rd_data_c   (rd_data_c),
        .req         (exec_req)
    );

    // Writeback uses the same bundle that leaves the top level
    register_file #(
        .REG_COUNT (REG_COUNT)
    ) register_file_inst (
        .clock     (clock),
        .rst_n     (rst_n),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_addr_c (rd_addr_c),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .rd_data_c (rd_data_c),
        .wr        (result)
    );

    bitmanip_unit bitmanip_unit_inst (
        .clock  (clock),
        .rst_n  (rst_n),
        .req    (exec_req),
        .result (result)
    );

endmodule

/* hw/bitmanip_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bit manipulation execution unit
// Steers each request to the population count pipeline or the bit
// field pipeline and merges the two equally timed results
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module bitmanip_unit (
    input  logic                    clock,
    input  logic                    rst_n,
    input  fcore_dp_pkg::exec_req_t req,
    output fcore_dp_pkg::exec_res_t result
);

    import fcore_isa_pkg::*;
    import fcore_dp_pkg::*;

    exec_req_t popcount_req;
    exec_req_t bitfield_req;
    exec_res_t popcount_res;
    exec_res_t bitfield_res;

    // Both pipes see the full request, only one of them sees it valid
    always_comb begin
        popcount_req       = req;
        bitfield_req       = req;
        popcount_req.valid = req.valid && (req.op == OP_POPCNT);
        bitfield_req.valid = req.valid && (req.op inside {OP_BEXT, OP_BINS, OP_LDI});
    end

    popcount_pipe popcount_pipe_inst (
        .clock  (clock),
        .rst_n  (rst_n),
        .req    (popcount_req),
        .result (popcount_res)
    );

    bitfield_pipe bitfield_pipe_inst (
        .clock  (clock),
        .rst_n  (rst_n),
        .req    (bitfield_req),
        .result (bitfield_res)
    );

    // Same latency in both pipes, so at most one result per cycle
    // An idle pipe drives zeros and the OR picks the active one
    assign result = exec_res_t'(popcount_res | bitfield_res);

    assert property (@(posedge clock) disable iff (!rst_n)
        !(popcount_res.valid && bitfield_res.valid))
    else $error("both pipelines produced a result in the same cycle");

endmodule

/* hw/fcore_dp_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Datapath definitions for the bit-manipulation slice
// Data width and the request and result bundles exchanged between
// the decoder, the execution pipelines and the register writeback
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package fcore_dp_pkg;

    // Width of every register and every result
    localparam int DATA_WIDTH = 32;

    // Operation bundle built by the decoder in the issue cycle
    // Operands are already read from the register file
    typedef struct packed {
        logic                    valid;
        fcore_isa_pkg::op_e      op;
        fcore_isa_pkg::reg_addr_t dest;
        logic [DATA_WIDTH-1:0]   operand_a;
        logic [DATA_WIDTH-1:0]   operand_b;
        logic [DATA_WIDTH-1:0]   operand_c;
    } exec_req_t;

    // Result bundle of a pipeline
    // A pipeline drives all zeros when its result is not valid so that
    // results of several pipelines can be merged with a plain OR
    typedef struct packed {
        logic                     valid;
        fcore_isa_pkg::reg_addr_t dest;
        logic [DATA_WIDTH-1:0]    data;
    } exec_res_t;

endpackage

/* hw/fcore_isa_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction set definitions for the bit-manipulation slice
// Opcode enum, register index type and the instruction word union
// with its register form and immediate form
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package fcore_isa_pkg;

    // Field widths of the 32-bit instruction word
    localparam int REG_ADDR_W = 4;
    localparam int IMM_W = 24;

    // Opcodes share the encoding used by the rest of the core
    typedef enum logic [3:0] {
        OP_NOP    = 4'h0,
        OP_LDI    = 4'h1,
        OP_POPCNT = 4'h3,
        OP_BEXT   = 4'h5,
        OP_BINS   = 4'h7
    } op_e;

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Register form with destination and up to three source registers
    typedef struct packed {
        op_e         opcode;
        reg_addr_t   rd;
        reg_addr_t   ra;
        reg_addr_t   rb;
        reg_addr_t   rc;
        logic [11:0] pad;
    } instr_reg_t;

    // Immediate form, the immediate is zero-extended to the data width
    typedef struct packed {
        op_e              opcode;
        reg_addr_t        rd;
        logic [IMM_W-1:0] imm;
    } instr_imm_t;

    // Opcode and rd sit at the same bit positions in both forms
    typedef union packed {
        instr_reg_t r;
        instr_imm_t i;
    } instr_u;

endpackage

/* hw/instr_decoder.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction decoder
// Turns the instruction strobe into register file read addresses
// and an operation bundle for the execution unit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module instr_decoder (
    input  logic                                instr_valid,
    input  fcore_isa_pkg::instr_u               instr,
    output fcore_isa_pkg::reg_addr_t            rd_addr_a,
    output fcore_isa_pkg::reg_addr_t            rd_addr_b,
    output fcore_isa_pkg::reg_addr_t            rd_addr_c,
    input  logic [fcore_dp_pkg::DATA_WIDTH-1:0] rd_data_a,
    input  logic [fcore_dp_pkg::DATA_WIDTH-1:0] rd_data_b,
    input  logic [fcore_dp_pkg::DATA_WIDTH-1:0] rd_data_c,
    output fcore_dp_pkg::exec_req_t             req
);

    import fcore_isa_pkg::*;
    import fcore_dp_pkg::*;

    // Source registers always come from the register form
    // For an immediate instruction the read data is simply ignored
    assign rd_addr_a = instr.r.ra;
    assign rd_addr_b = instr.r.rb;
    assign rd_addr_c = instr.r.rc;

    always_comb begin
        req.valid     = 1'b0;
        req.op        = OP_NOP;
        req.dest      = instr.r.rd;
        req.operand_a = rd_data_a;
        req.operand_b = rd_data_b;
        req.operand_c = rd_data_c;

        case (instr.r.opcode)
            OP_LDI: begin
                req.valid     = instr_valid;
                req.op        = OP_LDI;
                req.operand_a = DATA_WIDTH'(instr.i.imm);
                req.operand_b = '0;
                req.operand_c = '0;
            end
            OP_POPCNT, OP_BEXT, OP_BINS: begin
                req.valid = instr_valid;
                req.op    = instr.r.opcode;
            end
            // NOP and any unknown opcode leave no trace in the pipelines
            default: begin
                req.valid = 1'b0;
                req.op    = OP_NOP;
            end
        endcase
    end

endmodule

/* hw/popcount_pipe.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Population count pipeline
// Stage 1 counts the set bits of each half-word, stage 2 adds the
// two partial counts into the result
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module popcount_pipe (
    input  logic                    clock,
    input  logic                    rst_n,
    input  fcore_dp_pkg::exec_req_t req,
    output fcore_dp_pkg::exec_res_t result
);

    import fcore_isa_pkg::*;
    import fcore_dp_pkg::*;

    localparam int HALF_W = DATA_WIDTH / 2;

    logic       s1_valid;
    reg_addr_t  s1_dest;
    logic [5:0] s1_count_lo;
    logic [5:0] s1_count_hi;

    logic                  s2_valid;
    reg_addr_t             s2_dest;
    logic [DATA_WIDTH-1:0] s2_data;

    function automatic logic [5:0] count_half(input logic [HALF_W-1:0] word);
        logic [5:0] count;
        count = '0;
        for (int i = 0; i < HALF_W; i++) begin
            count = count + 6'(word[i]);
        end
        return count;
    endfunction

    // Valid state, the unit has already qualified req.valid by opcode
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= req.valid;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clock) begin
        s1_dest     <= req.dest;
        s1_count_lo <= count_half(req.operand_a[HALF_W-1:0]);
        s1_count_hi <= count_half(req.operand_a[DATA_WIDTH-1:HALF_W]);
        s2_dest     <= s1_dest;
        s2_data     <= DATA_WIDTH'(7'(s1_count_lo) + 7'(s1_count_hi));
    end

    // Idle output is all zeros so the unit can OR the two pipelines
    always_comb begin
        result = '0;
        if (s2_valid) begin
            result.valid = 1'b1;
            result.dest  = s2_dest;
            result.data  = s2_data;
        end
    end

endmodule

/* hw/register_file.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file
// Three combinational read ports and one synchronous write port fed
// by the execution unit result
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module register_file #(
    parameter int REG_COUNT = 16
) (
    input  logic                                clock,
    input  logic                                rst_n,
    input  fcore_isa_pkg::reg_addr_t            rd_addr_a,
    input  fcore_isa_pkg::reg_addr_t            rd_addr_b,
    input  fcore_isa_pkg::reg_addr_t            rd_addr_c,
    output logic [fcore_dp_pkg::DATA_WIDTH-1:0] rd_data_a,
    output logic [fcore_dp_pkg::DATA_WIDTH-1:0] rd_data_b,
    output logic [fcore_dp_pkg::DATA_WIDTH-1:0] rd_data_c,
    input  fcore_dp_pkg::exec_res_t             wr
);

    import fcore_isa_pkg::*;
    import fcore_dp_pkg::*;

    logic [DATA_WIDTH-1:0] regs [REG_COUNT];

    // Addresses past the implemented registers read as zero
    always_comb begin
        rd_data_a = (int'(rd_addr_a) < REG_COUNT) ? regs[rd_addr_a] : '0;
        rd_data_b = (int'(rd_addr_b) < REG_COUNT) ? regs[rd_addr_b] : '0;
        rd_data_c = (int'(rd_addr_c) < REG_COUNT) ? regs[rd_addr_c] : '0;
    end

    // Reads see the old value during the cycle in which a write happens
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.valid && (int'(wr.dest) < REG_COUNT)) begin
            regs[wr.dest] <= wr.data;
        end
    end

    // The issuer must never target a register that is not implemented
    assert property (@(posedge clock) disable iff (!rst_n)
        wr.valid |-> (int'(wr.dest) < REG_COUNT))
    else $error("register write to index %0d beyond %0d registers", wr.dest, REG_COUNT);

endmodule

/* tb/bitmanip_core_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the bit-manipulation slice
// Stimulus table built at time zero, a register model that predicts
// each result, a check task and a cycle limit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module bitmanip_core_tb;

    import fcore_isa_pkg::*;
    import fcore_dp_pkg::*;

    localparam int REG_COUNT = 16;
    localparam int RESET_CYCLES = 8;

    logic      clock;
    logic      rst_n;
    logic      instr_valid;
    instr_u    instr;
    exec_res_t result;

    // Stimulus table with one entry per cycle
    instr_u row_word [$];
    logic   row_valid [$];
    string  row_name [$];

    // Results still in flight and the loop cycle in which each is due
    int          exp_due [$];
    reg_addr_t   exp_dest [$];
    logic [31:0] exp_data [$];
    string       exp_name [$];

    logic [31:0] model_regs [REG_COUNT];
    int          last_write [REG_COUNT];
    logic [31:0] rand_state;
    int          cycle_count;
    int          cycle_limit;

    bitmanip_core #(
        .REG_COUNT (REG_COUNT)
    ) bitmanip_core_inst (
        .clock       (clock),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .result      (result)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] count_ones(input logic [31:0] value);
        logic [31:0] count;
        count = 0;
        for (int i = 0; i < 32; i++) begin
            count = count + value[i];
        end
        return count;
    endfunction

    function automatic instr_u reg_form_word(input op_e op, input reg_addr_t rd,
                                             input reg_addr_t ra, input reg_addr_t rb,
                                             input reg_addr_t rc);
        instr_u w;
        w.r.opcode = op;
        w.r.rd     = rd;
        w.r.ra     = ra;
        w.r.rb     = rb;
        w.r.rc     = rc;
        w.r.pad    = '0;
        return w;
    endfunction

    function automatic instr_u imm_form_word(input reg_addr_t rd, input logic [23:0] imm);
        instr_u w;
        w.i.opcode = OP_LDI;
        w.i.rd     = rd;
        w.i.imm    = imm;
        return w;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic pad_idle(input int count);
        for (int i = 0; i < count; i++) begin
            row_word.push_back('0);
            row_valid.push_back(1'b0);
            row_name.push_back("idle");
        end
    endtask

    // Idle rows go in first so that every source register has been
    // written back before the instruction reads it
    task automatic add_instr(input instr_u w, input logic valid, input string name);
        int need;
        op_e op;
        need = 0;
        op = w.r.opcode;
        if (valid && (op inside {OP_POPCNT, OP_BEXT, OP_BINS})) begin
            need = last_write[w.r.ra] + 3;
        end
        if (valid && (op inside {OP_BEXT, OP_BINS}) && (last_write[w.r.rb] + 3 > need)) begin
            need = last_write[w.r.rb] + 3;
        end
        if (valid && (op == OP_BINS) && (last_write[w.r.rc] + 3 > need)) begin
            need = last_write[w.r.rc] + 3;
        end
        while (row_word.size() < need) begin
            pad_idle(1);
        end
        if (valid && (op inside {OP_LDI, OP_POPCNT, OP_BEXT, OP_BINS})) begin
            last_write[w.r.rd] = row_word.size();
        end
        row_word.push_back(w);
        row_valid.push_back(valid);
        row_name.push_back(name);
    endtask

    task automatic build_table();
        reg_addr_t idx;
        add_instr(imm_form_word(1, 24'hABCDEF), 1'b1, "ldi pattern");
        add_instr(imm_form_word(2, 24'h000000), 1'b1, "ldi zero");
        add_instr(imm_form_word(5, 24'h000001), 1'b1, "ldi one");
        rand_state = xorshift32(rand_state);
        add_instr(imm_form_word(3, rand_state[23:0]), 1'b1, "ldi random");
        add_instr(imm_form_word(4, 24'hFFFFFF), 1'b1, "ldi low ones");
        add_instr(reg_form_word(OP_NOP, 8, 1, 2, 3), 1'b1, "nop");
        add_instr(reg_form_word(OP_POPCNT, 8, 1, 0, 0), 1'b0, "masked popcount");
        add_instr(reg_form_word(op_e'(4'hF), 8, 1, 0, 0), 1'b1, "unknown opcode");

        // Fill the top byte of r4 so that r7 ends up holding index 31
        for (int b = 24; b < 32; b++) begin
            idx = (b % 2 == 1) ? 4'd7 : 4'd6;
            add_instr(imm_form_word(idx, 24'(b)), 1'b1, "ldi index");
            add_instr(reg_form_word(OP_BINS, 4, 4, idx, 5), 1'b1, "bins set high bit");
        end

        add_instr(reg_form_word(OP_POPCNT, 8, 2, 0, 0), 1'b1, "popcount zero");
        add_instr(reg_form_word(OP_POPCNT, 8, 4, 0, 0), 1'b1, "popcount all ones");
        add_instr(reg_form_word(OP_POPCNT, 8, 1, 0, 0), 1'b1, "popcount pattern");
        add_instr(imm_form_word(9, 24'h12FFFF), 1'b1, "ldi halves differ");
        add_instr(reg_form_word(OP_POPCNT, 8, 9, 0, 0), 1'b1, "popcount halves differ");
        for (int i = 0; i < 3; i++) begin
            rand_state = xorshift32(rand_state);
            add_instr(imm_form_word(9, 24'(1) << (rand_state % 24)), 1'b1, "ldi one-hot");
            add_instr(reg_form_word(OP_POPCNT, 8, 9, 0, 0), 1'b1, "popcount one-hot");
        end
        add_instr(reg_form_word(OP_BINS, 9, 2, 7, 5), 1'b1, "bins set bit 31");
        add_instr(reg_form_word(OP_POPCNT, 8, 9, 0, 0), 1'b1, "popcount bit 31");
        for (int i = 0; i < 4; i++) begin
            rand_state = xorshift32(rand_state);
            add_instr(imm_form_word(10, rand_state[23:0]), 1'b1, "ldi random word");
            idx = rand_state[31] ? 4'd5 : 4'd2;
            add_instr(reg_form_word(OP_BINS, 10, 10, 7, idx), 1'b1, "bins random top bit");
            add_instr(reg_form_word(OP_POPCNT, 8, 10, 0, 0), 1'b1, "popcount random");
        end

        add_instr(reg_form_word(OP_BEXT, 12, 10, 2, 0), 1'b1, "bext index 0");
        add_instr(reg_form_word(OP_BEXT, 12, 10, 7, 0), 1'b1, "bext index 31");
        add_instr(reg_form_word(OP_BEXT, 12, 9, 7, 0), 1'b1, "bext one-hot 31");
        for (int i = 0; i < 4; i++) begin
            rand_state = xorshift32(rand_state);
            // Upper index bits are set and must be ignored
            add_instr(imm_form_word(11, rand_state[23:0] | 24'h000100), 1'b1, "ldi index");
            add_instr(reg_form_word(OP_BEXT, 12, 10, 11, 0), 1'b1, "bext random index");
            add_instr(reg_form_word(OP_BEXT, 12, 1, 11, 0), 1'b1, "bext pattern");
        end

        add_instr(reg_form_word(OP_BINS, 13, 4, 7, 2), 1'b1, "bins clear bit 31");
        add_instr(reg_form_word(OP_BINS, 13, 13, 2, 2), 1'b1, "bins clear bit 0");
        add_instr(reg_form_word(OP_BINS, 14, 2, 2, 5), 1'b1, "bins set bit 0");
        add_instr(reg_form_word(OP_POPCNT, 15, 13, 0, 0), 1'b1, "popcount readback");
        for (int i = 0; i < 4; i++) begin
            rand_state = xorshift32(rand_state);
            add_instr(imm_form_word(11, rand_state[23:0]), 1'b1, "ldi index");
            idx = rand_state[30] ? 4'd5 : 4'd2;
            add_instr(reg_form_word(OP_BINS, 14, 10, 11, idx), 1'b1, "bins random");
            add_instr(reg_form_word(OP_POPCNT, 15, 14, 0, 0), 1'b1, "popcount readback");
        end

        // Three independent instructions issued on consecutive cycles
        pad_idle(3);
        add_instr(reg_form_word(OP_POPCNT, 12, 4, 0, 0), 1'b1, "back-to-back popcount");
        add_instr(reg_form_word(OP_BEXT, 13, 10, 11, 0), 1'b1, "back-to-back bext");
        add_instr(reg_form_word(OP_BINS, 14, 1, 11, 5), 1'b1, "back-to-back bins");
        add_instr(reg_form_word(OP_NOP, 0, 0, 0, 0), 1'b1, "trailing nop");
        pad_idle(2);
    endtask

    // Drives one table row and predicts its result from the model
    task automatic drive_row(input int k);
        instr_u      w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] data;
        logic        has_result;
        w = row_word[k];
        instr = w;
        instr_valid = row_valid[k];
        a = model_regs[w.r.ra];
        b = model_regs[w.r.rb];
        c = model_regs[w.r.rc];
        data = '0;
        has_result = row_valid[k];
        case (w.r.opcode)
            OP_LDI:    data = {8'h00, w.i.imm};
            OP_POPCNT: data = count_ones(a);
            OP_BEXT:   data[0] = a[b[4:0]];
            OP_BINS: begin
                data = a;
                data[b[4:0]] = c[0];
            end
            default:   has_result = 1'b0;
        endcase
        if (has_result) begin
            model_regs[w.r.rd] = data;
            exp_due.push_back(k + 2);
            exp_dest.push_back(w.r.rd);
            exp_data.push_back(data);
            exp_name.push_back(row_name[k]);
        end
    endtask

    task automatic check_result(input int k);
        string name;
        if (exp_due.size() > 0 && exp_due[0] == k) begin
            name = exp_name.pop_front();
            void'(exp_due.pop_front());
            check_value({name, " valid"}, 32'd1, 32'(result.valid));
            check_value({name, " dest"}, 32'(exp_dest.pop_front()), 32'(result.dest));
            check_value({name, " data"}, exp_data.pop_front(), result.data);
        end else begin
            check_value($sformatf("no result in cycle %0d", k), 32'd0, 32'(result.valid));
        end
    endtask

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clock);
            cycle_count++;
            if (cycle_limit > 0 && cycle_count > cycle_limit) begin
                $display("Timeout: the run did not end within %0d cycles", cycle_limit);
                $display("STATUS: FAIL");
                $fatal(1, "cycle limit reached");
            end
        end
    end

    initial begin
        rst_n = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        cycle_limit = 0;
        rand_state = 32'd19124;
        for (int i = 0; i < REG_COUNT; i++) begin
            model_regs[i] = '0;
            last_write[i] = -10;
        end
        build_table();
        cycle_limit = row_word.size() + RESET_CYCLES + 20;

        repeat (RESET_CYCLES) @(posedge clock);
        #2;
        rst_n = 1'b1;

        // Two extra cycles drain the last results
        for (int k = 0; k < row_word.size() + 2; k++) begin
            @(posedge clock);
            #2;
            check_result(k);
            if (k < row_word.size()) begin
                drive_row(k);
            end else begin
                instr_valid = 1'b0;
                instr = '0;
            end
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule
